// ==== design/video_pkg.sv ====
`default_nettype none

package video_pkg;

	localparam int SRAM_ADDRESS_SIZE = 9;	// Word address width of one bank
	localparam int WORD_ADDRESS_BITS = SRAM_ADDRESS_SIZE + 1;
	localparam int BUS_ADDRESS_BITS = 13;

	// Line phases in pixels
	localparam int H_VISIBLE = 16;
	localparam int H_FRONT = 2;
	localparam int H_SYNC = 4;
	localparam int H_BACK = 2;
	localparam int LINE_CYCLES = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
	localparam int H_SYNC_START = H_VISIBLE + H_FRONT;

	// Frame phases in lines
	localparam int V_VISIBLE = 8;
	localparam int V_FRONT = 1;
	localparam int V_SYNC = 2;
	localparam int V_BACK = 1;
	localparam int FRAME_LINES = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
	localparam int V_SYNC_START = V_VISIBLE + V_FRONT;

	localparam int H_COUNT_BITS = $clog2(LINE_CYCLES);
	localparam int V_COUNT_BITS = $clog2(FRAME_LINES);
	localparam int WORDS_PER_LINE = H_VISIBLE / 4;	// Four pixels per word
	localparam int PIXEL_LATENCY = 2;

	localparam int REG_SPACE_BIT = 12;
	localparam int BANK_BIT = SRAM_ADDRESS_SIZE + 2;	// Word bit 9 as a byte address bit
	localparam logic [REG_SPACE_BIT-1:0] CONTROL_OFFSET = 'h000;
	localparam logic [REG_SPACE_BIT-1:0] STATUS_OFFSET = 'h004;

	// CONTROL layout
	localparam int CTRL_ENABLE_BIT = 0;
	localparam int CTRL_IRQ_LSB = 8;

	typedef enum logic [1:0] {
		IDLE,
		WAIT,
		RESPOND
	} bridge_state_e;

	typedef enum logic [1:0] {
		REG_CONTROL,
		REG_STATUS,
		REG_NONE
	} reg_sel_e;

	typedef struct packed {
		logic we;
		logic oe;
		logic [BUS_ADDRESS_BITS-1:0] address;
		logic [3:0] byte_select;
		logic [31:0] write_data;
	} pbus_req_t;

	typedef struct packed {
		logic busy;
		logic claim;
		logic [31:0] read_data;
	} pbus_rsp_t;

	typedef struct packed {
		logic csb;	// Active low chip select
		logic web;	// Active low write enable
		logic [3:0] wmask;
		logic [SRAM_ADDRESS_SIZE-1:0] addr;
		logic [31:0] din;
	} sram_port_t;

	typedef struct packed {
		logic enable;
		logic [1:0] irq_enable;
	} vga_ctrl_t;

	typedef struct packed {
		logic fetch;
		logic [WORD_ADDRESS_BITS-1:0] word_address;
	} pixel_fetch_t;

endpackage

`default_nettype wire

// ==== design/wb_periph_bridge.sv ====
`default_nettype none

module wb_periph_bridge (
	input wire logic wb_clk_i,
	input wire logic reset_i,
	input wire logic wb_cyc_i,
	input wire logic wb_stb_i,
	input wire logic wb_we_i,
	input wire logic [3:0] wb_sel_i,
	input wire logic [23:0] wb_adr_i,
	input wire logic [31:0] wb_data_i,
	output logic wb_ack_o,
	output logic wb_stall_o,
	output logic wb_error_o,
	output logic [31:0] wb_data_o,
	output video_pkg::pbus_req_t req_o,
	input wire video_pkg::pbus_rsp_t rsp_i
);

	video_pkg::bridge_state_e state_q;
	logic issue_we_q, issue_oe_q;
	logic unmapped_q;
	logic [video_pkg::BUS_ADDRESS_BITS-1:0] address_q;
	logic [3:0] sel_q;
	logic [31:0] wdata_q;
	logic accept, in_range, fail;

	assign accept = wb_cyc_i && wb_stb_i && !wb_stall_o;
	assign in_range = ~|wb_adr_i[23:video_pkg::BUS_ADDRESS_BITS];
	assign fail = unmapped_q || !rsp_i.claim;	// Nobody owns the address

	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			state_q <= video_pkg::IDLE;
			issue_we_q <= 1'b0;
			issue_oe_q <= 1'b0;
			wb_ack_o <= 1'b0;
			wb_error_o <= 1'b0;
		end else begin
			issue_we_q <= 1'b0;	// Strobes last one cycle
			issue_oe_q <= 1'b0;
			wb_ack_o <= 1'b0;
			wb_error_o <= 1'b0;
			case (state_q)
				video_pkg::IDLE: if (accept) begin
					state_q <= video_pkg::WAIT;
					issue_we_q <= wb_we_i && in_range;
					issue_oe_q <= !wb_we_i && in_range;
				end
				video_pkg::WAIT: state_q <= video_pkg::RESPOND;
				video_pkg::RESPOND: if (!rsp_i.busy) begin
					state_q <= video_pkg::IDLE;
					wb_ack_o <= !fail;
					wb_error_o <= fail;
				end
				default: state_q <= video_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (accept) begin
			unmapped_q <= !in_range;
			address_q <= wb_adr_i[video_pkg::BUS_ADDRESS_BITS-1:0];
			sel_q <= wb_sel_i;
			wdata_q <= wb_data_i;
		end
		if (state_q == video_pkg::RESPOND && !rsp_i.busy)
			wb_data_o <= fail ? '1 : rsp_i.read_data;
	end

	assign wb_stall_o = state_q != video_pkg::IDLE;
	assign req_o = '{we: issue_we_q, oe: issue_oe_q, address: address_q,
		byte_select: sel_q, write_data: wdata_q};

endmodule

`default_nettype wire

// ==== design/video_memory.sv ====
`default_nettype none

module video_memory (
	input wire logic wb_clk_i,
	input wire logic reset_i,
	input wire video_pkg::pbus_req_t req_i,
	output video_pkg::pbus_rsp_t rsp_o,
	input wire video_pkg::pixel_fetch_t fetch_i,
	output logic [31:0] pixel_data_o,
	output video_pkg::sram_port_t sram0_port_o,
	output video_pkg::sram_port_t sram1_port_o,
	input wire logic [31:0] sram0_dout0_i,
	input wire logic [31:0] sram1_dout0_i,
	output logic sram0_csb1_o,
	output logic [video_pkg::SRAM_ADDRESS_SIZE-1:0] sram0_addr1_o,
	input wire logic [31:0] sram0_dout1_i,
	output logic sram1_csb1_o,
	output logic [video_pkg::SRAM_ADDRESS_SIZE-1:0] sram1_addr1_o,
	input wire logic [31:0] sram1_dout1_i
);

	logic claim, access, bank;
	logic rd_bank_q;

	function automatic video_pkg::sram_port_t rw_command(
		input video_pkg::pbus_req_t req,
		input logic selected
	);
		video_pkg::sram_port_t cmd;
		cmd.csb = !selected;
		cmd.web = !req.we;
		cmd.wmask = req.byte_select;
		cmd.addr = req.address[2 +: video_pkg::SRAM_ADDRESS_SIZE];
		cmd.din = req.write_data;
		return cmd;
	endfunction

	assign claim = !req_i.address[video_pkg::REG_SPACE_BIT];
	assign access = (req_i.we || req_i.oe) && claim;
	assign bank = req_i.address[video_pkg::BANK_BIT];	// Set for the right bank

	assign sram0_port_o = rw_command(req_i, access && !bank);
	assign sram1_port_o = rw_command(req_i, access && bank);

	// Pixel fetches only use the left bank's read port
	assign sram0_csb1_o = !fetch_i.fetch;
	assign sram0_addr1_o = fetch_i.word_address[video_pkg::SRAM_ADDRESS_SIZE-1:0];
	assign sram1_csb1_o = 1'b1;	// Right bank is CPU-only storage
	assign sram1_addr1_o = '0;

	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			rd_bank_q <= 1'b0;
		end else begin
			if (req_i.oe && claim)
				rd_bank_q <= bank;
		end
	end

	assign pixel_data_o = sram0_dout1_i;

	// Busy covers the cycle in which the SRAM is reading
	assign rsp_o = '{busy: req_i.oe && claim, claim: claim,
		read_data: rd_bank_q ? sram1_dout0_i : sram0_dout0_i};

endmodule

`default_nettype wire

// ==== design/vga_regs.sv ====
`default_nettype none

module vga_regs (
	input wire logic wb_clk_i,
	input wire logic reset_i,
	input wire video_pkg::pbus_req_t req_i,
	output video_pkg::pbus_rsp_t rsp_o,
	input wire logic vsync_start_i,
	input wire logic hsync_start_i,
	output video_pkg::vga_ctrl_t ctrl_o,
	output logic [1:0] irq_o
);

	video_pkg::reg_sel_e sel;
	video_pkg::vga_ctrl_t ctrl_q;
	logic [1:0] status_q;
	logic [1:0] clear;
	logic [31:0] control_word;
	logic [31:0] read_q;

	always_comb begin
		sel = video_pkg::REG_NONE;
		if (req_i.address[video_pkg::REG_SPACE_BIT]) begin
			if (req_i.address[video_pkg::REG_SPACE_BIT-1:0] == video_pkg::CONTROL_OFFSET)
				sel = video_pkg::REG_CONTROL;
			else if (req_i.address[video_pkg::REG_SPACE_BIT-1:0] == video_pkg::STATUS_OFFSET)
				sel = video_pkg::REG_STATUS;
		end
	end

	always_comb begin
		control_word = '0;
		control_word[video_pkg::CTRL_ENABLE_BIT] = ctrl_q.enable;
		control_word[video_pkg::CTRL_IRQ_LSB +: 2] = ctrl_q.irq_enable;
	end

	// Write one to clear
	assign clear = (req_i.we && sel == video_pkg::REG_STATUS && req_i.byte_select[0]) ?
		req_i.write_data[1:0] : 2'b00;

	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			ctrl_q <= '0;
			status_q <= '0;
		end else begin
			if (req_i.we && sel == video_pkg::REG_CONTROL) begin
				if (req_i.byte_select[video_pkg::CTRL_ENABLE_BIT / 8])
					ctrl_q.enable <= req_i.write_data[video_pkg::CTRL_ENABLE_BIT];
				if (req_i.byte_select[video_pkg::CTRL_IRQ_LSB / 8])
					ctrl_q.irq_enable <= req_i.write_data[video_pkg::CTRL_IRQ_LSB +: 2];
			end
			// A new event wins over a clear in the same cycle
			status_q <= (status_q & ~clear) |
				({hsync_start_i, vsync_start_i} & ctrl_q.irq_enable);
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (req_i.oe)
			read_q <= (sel == video_pkg::REG_STATUS) ? {30'b0, status_q} : control_word;
	end

	assign rsp_o = '{busy: req_i.oe && sel != video_pkg::REG_NONE,
		claim: sel != video_pkg::REG_NONE, read_data: read_q};
	assign ctrl_o = ctrl_q;
	assign irq_o = status_q;

endmodule

`default_nettype wire

// ==== design/vga_timing.sv ====
`default_nettype none

module vga_timing (
	input wire logic wb_clk_i,
	input wire logic reset_i,
	input wire video_pkg::vga_ctrl_t ctrl_i,
	output video_pkg::pixel_fetch_t fetch_o,
	input wire logic [31:0] pixel_data_i,
	output logic vsync_start_o,
	output logic hsync_start_o,
	output logic [1:0] vga_r_o,
	output logic [1:0] vga_g_o,
	output logic [1:0] vga_b_o,
	output logic vga_hsync_o,
	output logic vga_vsync_o
);

	localparam int AW = video_pkg::WORD_ADDRESS_BITS;

	logic [video_pkg::H_COUNT_BITS-1:0] h_q, h_next;
	logic [video_pkg::V_COUNT_BITS-1:0] v_q, v_next;
	logic visible, next_visible;
	logic hsync_n, vsync_n;
	logic [video_pkg::PIXEL_LATENCY-1:0] hsync_pipe, vsync_pipe;
	logic visible_q, fetch_q;
	logic [1:0] x_q;
	logic [31:0] word_q;
	logic [7:0] pixel_byte;
	logic [5:0] colour_q;

	always_comb begin
		h_next = h_q + 1'b1;
		v_next = v_q;
		if (h_q == video_pkg::LINE_CYCLES - 1) begin
			h_next = '0;
			v_next = (v_q == video_pkg::FRAME_LINES - 1) ? '0 : v_q + 1'b1;
		end
	end

	// Counters sit at 0,0 while the block is stopped
	always_ff @(posedge wb_clk_i) begin
		if (reset_i || !ctrl_i.enable) begin
			h_q <= '0;
			v_q <= '0;
		end else begin
			h_q <= h_next;
			v_q <= v_next;
		end
	end

	assign visible = ctrl_i.enable && h_q < video_pkg::H_VISIBLE && v_q < video_pkg::V_VISIBLE;
	assign next_visible = h_next < video_pkg::H_VISIBLE && v_next < video_pkg::V_VISIBLE;
	assign hsync_n = !(ctrl_i.enable && h_q >= video_pkg::H_SYNC_START &&
		h_q < video_pkg::H_SYNC_START + video_pkg::H_SYNC);
	assign vsync_n = !(ctrl_i.enable && v_q >= video_pkg::V_SYNC_START &&
		v_q < video_pkg::V_SYNC_START + video_pkg::V_SYNC);

	assign hsync_start_o = ctrl_i.enable && h_q == video_pkg::H_SYNC_START;
	assign vsync_start_o = ctrl_i.enable && v_q == video_pkg::V_SYNC_START && h_q == 0;

	// Next group's word is requested one pixel before it starts
	assign fetch_o.fetch = ctrl_i.enable && next_visible && h_next[1:0] == 2'b00;
	assign fetch_o.word_address = AW'(v_next) * AW'(video_pkg::WORDS_PER_LINE) + AW'(h_next >> 2);

	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			visible_q <= 1'b0;
			fetch_q <= 1'b0;
			colour_q <= '0;
			hsync_pipe <= '1;
			vsync_pipe <= '1;
		end else begin
			visible_q <= visible;
			fetch_q <= fetch_o.fetch;	// Memory word arrives this cycle
			colour_q <= visible_q ? pixel_byte[5:0] : 6'b0;
			hsync_pipe <= {hsync_pipe[video_pkg::PIXEL_LATENCY-2:0], hsync_n};
			vsync_pipe <= {vsync_pipe[video_pkg::PIXEL_LATENCY-2:0], vsync_n};
		end
	end

	always_ff @(posedge wb_clk_i) begin
		x_q <= h_q[1:0];
		if (fetch_q)
			word_q <= pixel_data_i;
	end

	assign pixel_byte = word_q[x_q * 8 +: 8];

	assign vga_r_o = colour_q[5:4];
	assign vga_g_o = colour_q[3:2];
	assign vga_b_o = colour_q[1:0];
	assign vga_hsync_o = hsync_pipe[video_pkg::PIXEL_LATENCY-1];
	assign vga_vsync_o = vsync_pipe[video_pkg::PIXEL_LATENCY-1];

endmodule

`default_nettype wire

// ==== design/video_top.sv ====
`default_nettype none

module video_top (
	input wire logic wb_clk_i,
	input wire logic reset_i,
	input wire logic wb_cyc_i,
	input wire logic wb_stb_i,
	input wire logic wb_we_i,
	input wire logic [3:0] wb_sel_i,
	input wire logic [23:0] wb_adr_i,
	input wire logic [31:0] wb_data_i,
	output logic wb_ack_o,
	output logic wb_stall_o,
	output logic wb_error_o,
	output logic [31:0] wb_data_o,
	output logic [1:0] video_irq_o,
	// Left bank
	output logic sram0_csb0_o,
	output logic sram0_web0_o,
	output logic [3:0] sram0_wmask0_o,
	output logic [video_pkg::SRAM_ADDRESS_SIZE-1:0] sram0_addr0_o,
	output logic [31:0] sram0_din0_o,
	input wire logic [31:0] sram0_dout0_i,
	output logic sram0_csb1_o,
	output logic [video_pkg::SRAM_ADDRESS_SIZE-1:0] sram0_addr1_o,
	input wire logic [31:0] sram0_dout1_i,
	// Right bank
	output logic sram1_csb0_o,
	output logic sram1_web0_o,
	output logic [3:0] sram1_wmask0_o,
	output logic [video_pkg::SRAM_ADDRESS_SIZE-1:0] sram1_addr0_o,
	output logic [31:0] sram1_din0_o,
	input wire logic [31:0] sram1_dout0_i,
	output logic sram1_csb1_o,
	output logic [video_pkg::SRAM_ADDRESS_SIZE-1:0] sram1_addr1_o,
	input wire logic [31:0] sram1_dout1_i,
	output logic [1:0] vga_r_o,
	output logic [1:0] vga_g_o,
	output logic [1:0] vga_b_o,
	output logic vga_hsync_o,
	output logic vga_vsync_o
);

	video_pkg::pbus_req_t req;
	video_pkg::pbus_rsp_t rsp, mem_rsp, reg_rsp;
	video_pkg::sram_port_t sram0_port, sram1_port;
	video_pkg::pixel_fetch_t fetch;
	video_pkg::vga_ctrl_t ctrl;
	logic [31:0] pixel_data;
	logic vsync_start, hsync_start;

	wb_periph_bridge i_bridge (
		.wb_clk_i, .reset_i,
		.wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_sel_i, .wb_adr_i, .wb_data_i,
		.wb_ack_o, .wb_stall_o, .wb_error_o, .wb_data_o,
		.req_o(req),
		.rsp_i(rsp)
	);

	video_memory i_memory (
		.wb_clk_i, .reset_i,
		.req_i(req),
		.rsp_o(mem_rsp),
		.fetch_i(fetch),
		.pixel_data_o(pixel_data),
		.sram0_port_o(sram0_port),
		.sram1_port_o(sram1_port),
		.sram0_dout0_i, .sram1_dout0_i,
		.sram0_csb1_o, .sram0_addr1_o, .sram0_dout1_i,
		.sram1_csb1_o, .sram1_addr1_o, .sram1_dout1_i
	);

	vga_regs i_regs (
		.wb_clk_i, .reset_i,
		.req_i(req),
		.rsp_o(reg_rsp),
		.vsync_start_i(vsync_start),
		.hsync_start_i(hsync_start),
		.ctrl_o(ctrl),
		.irq_o(video_irq_o)
	);

	vga_timing i_timing (
		.wb_clk_i, .reset_i,
		.ctrl_i(ctrl),
		.fetch_o(fetch),
		.pixel_data_i(pixel_data),
		.vsync_start_o(vsync_start),
		.hsync_start_o(hsync_start),
		.vga_r_o, .vga_g_o, .vga_b_o, .vga_hsync_o, .vga_vsync_o
	);

	assign rsp.busy = mem_rsp.busy || reg_rsp.busy;
	assign rsp.claim = mem_rsp.claim || reg_rsp.claim;
	assign rsp.read_data = mem_rsp.claim ? mem_rsp.read_data : reg_rsp.read_data;

	assign sram0_csb0_o = sram0_port.csb;
	assign sram0_web0_o = sram0_port.web;
	assign sram0_wmask0_o = sram0_port.wmask;
	assign sram0_addr0_o = sram0_port.addr;
	assign sram0_din0_o = sram0_port.din;

	assign sram1_csb0_o = sram1_port.csb;
	assign sram1_web0_o = sram1_port.web;
	assign sram1_wmask0_o = sram1_port.wmask;
	assign sram1_addr0_o = sram1_port.addr;
	assign sram1_din0_o = sram1_port.din;

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
`default_nettype none

module tb_clock (
	output logic clk_o,
	output logic reset_o
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk_o = 1'b0;
		forever #2 clk_o = ~clk_o;	// 4 ns period
	end

	initial begin
		reset_o = 1'b1;
		repeat (3) @(posedge clk_o);
		@(negedge clk_o);
		reset_o = 1'b0;
	end

endmodule

`default_nettype wire

// ==== test/sram_bank_model.sv ====
`default_nettype none

module sram_bank_model (
	input wire logic clk_i,
	input wire logic csb0_i,
	input wire logic web0_i,
	input wire logic [3:0] wmask0_i,
	input wire logic [video_pkg::SRAM_ADDRESS_SIZE-1:0] addr0_i,
	input wire logic [31:0] din0_i,
	output logic [31:0] dout0_o,
	input wire logic csb1_i,
	input wire logic [video_pkg::SRAM_ADDRESS_SIZE-1:0] addr1_i,
	output logic [31:0] dout1_o
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int DEPTH = 1 << video_pkg::SRAM_ADDRESS_SIZE;

	logic [31:0] mem [0:DEPTH-1];

	// Power-up contents that differ for every word
	initial begin
		dout0_o = '0;
		dout1_o = '0;
		for (int i = 0; i < DEPTH; i++)
			mem[i] = 32'h5a000000 ^ (i * 32'h00010203);
	end

	always @(posedge clk_i) begin
		if (!csb0_i) begin
			if (!web0_i) begin
				for (int b = 0; b < 4; b++)
					if (wmask0_i[b])
						mem[addr0_i][b*8 +: 8] <= din0_i[b*8 +: 8];
			end else begin
				dout0_o <= mem[addr0_i];
			end
		end
		if (!csb1_i)
			dout1_o <= mem[addr1_i];	// Read port
	end

endmodule

`default_nettype wire

// ==== test/video_tb.sv ====
`default_nettype none

module video_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int FRAME_CYCLES = video_pkg::FRAME_LINES * video_pkg::LINE_CYCLES;
	localparam logic [23:0] CONTROL_ADR = 24'h1000;
	localparam logic [23:0] STATUS_ADR = 24'h1004;

	logic clk, reset;
	logic wb_cyc_i, wb_stb_i, wb_we_i;
	logic [3:0] wb_sel_i;
	logic [23:0] wb_adr_i;
	logic [31:0] wb_data_i, wb_data_o;
	logic wb_ack_o, wb_stall_o, wb_error_o;
	logic [1:0] video_irq_o, vga_r_o, vga_g_o, vga_b_o;
	logic vga_hsync_o, vga_vsync_o;
	logic s0_csb0, s0_web0, s0_csb1, s1_csb0, s1_web0, s1_csb1;
	logic [3:0] s0_wmask0, s1_wmask0;
	logic [video_pkg::SRAM_ADDRESS_SIZE-1:0] s0_addr0, s0_addr1, s1_addr0, s1_addr1;
	logic [31:0] s0_din0, s0_dout0, s0_dout1, s1_din0, s1_dout0, s1_dout1;

	logic [31:0] shadow [0:31];	// Visible left-bank words, power-up fill plus writes
	int cycle_count = 0;
	int cycle_limit = 0;
	int seed = 31763;

	tb_clock i_clock (.clk_o(clk), .reset_o(reset));

	video_top i_dut (
		.wb_clk_i(clk), .reset_i(reset),
		.wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_sel_i, .wb_adr_i, .wb_data_i,
		.wb_ack_o, .wb_stall_o, .wb_error_o, .wb_data_o, .video_irq_o,
		.sram0_csb0_o(s0_csb0), .sram0_web0_o(s0_web0), .sram0_wmask0_o(s0_wmask0),
		.sram0_addr0_o(s0_addr0), .sram0_din0_o(s0_din0), .sram0_dout0_i(s0_dout0),
		.sram0_csb1_o(s0_csb1), .sram0_addr1_o(s0_addr1), .sram0_dout1_i(s0_dout1),
		.sram1_csb0_o(s1_csb0), .sram1_web0_o(s1_web0), .sram1_wmask0_o(s1_wmask0),
		.sram1_addr0_o(s1_addr0), .sram1_din0_o(s1_din0), .sram1_dout0_i(s1_dout0),
		.sram1_csb1_o(s1_csb1), .sram1_addr1_o(s1_addr1), .sram1_dout1_i(s1_dout1),
		.vga_r_o, .vga_g_o, .vga_b_o, .vga_hsync_o, .vga_vsync_o
	);

	sram_bank_model i_sram0 (
		.clk_i(clk), .csb0_i(s0_csb0), .web0_i(s0_web0), .wmask0_i(s0_wmask0),
		.addr0_i(s0_addr0), .din0_i(s0_din0), .dout0_o(s0_dout0),
		.csb1_i(s0_csb1), .addr1_i(s0_addr1), .dout1_o(s0_dout1)
	);

	sram_bank_model i_sram1 (
		.clk_i(clk), .csb0_i(s1_csb0), .web0_i(s1_web0), .wmask0_i(s1_wmask0),
		.addr0_i(s1_addr0), .din0_i(s1_din0), .dout0_o(s1_dout0),
		.csb1_i(s1_csb1), .addr1_i(s1_addr1), .dout1_o(s1_dout1)
	);

	task automatic stop_on_error(input string reason);
		$display("%s", reason);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else
			stop_on_error($sformatf("Fail %s: got %h expected %h", name, got, exp));
	endtask

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count > cycle_limit)
			stop_on_error($sformatf("Timeout: no result after %0d cycles", cycle_limit));
	end

	// One Wishbone cycle, checking stall and the fixed response delay
	task automatic bus_cycle(input logic we, input logic [23:0] adr, input logic [31:0] data,
		input logic [3:0] sel, output logic err, output logic [31:0] rdata);
		int waited;
		@(negedge clk);
		check_value("wb_stall_o", wb_stall_o, 0);
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i = we;
		wb_adr_i = adr;
		wb_data_i = data;
		wb_sel_i = sel;
		@(negedge clk);
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		waited = 0;
		while (!(wb_ack_o || wb_error_o)) begin
			check_value("wb_stall_o", wb_stall_o, 1);
			@(negedge clk);
			waited++;
			assert (waited < 8) else stop_on_error("Bus cycle got neither ack nor error");
		end
		check_value("ack delay", waited, 2);
		check_value("wb_ack_o", wb_ack_o, !wb_error_o);
		err = wb_error_o;
		rdata = wb_data_o;
	endtask

	task automatic bus_write(input logic [23:0] adr, input logic [31:0] data, input logic [3:0] sel);
		logic err;
		logic [31:0] rdata;
		bus_cycle(1'b1, adr, data, sel, err, rdata);
		check_value("wb_error_o", err, 0);
		if (adr < 24'h80) begin
			for (int b = 0; b < 4; b++)
				if (sel[b])
					shadow[adr[6:2]][b*8 +: 8] = data[b*8 +: 8];
		end
	endtask

	task automatic wait_rise(input int which);
		logic prev, now;
		prev = 1'b1;
		forever begin
			@(negedge clk);
			now = (which == 0) ? video_irq_o[0] : (which == 1) ? video_irq_o[1] : vga_hsync_o;
			if (!prev && now)
				break;
			prev = now;
		end
	endtask

	// Walks one frame from the vsync falling edge, as position 0,9
	task automatic frame_check();
		int h, v, w;
		logic prev;
		logic [5:0] exp;
		prev = 1'b1;
		forever begin
			@(negedge clk);
			if (prev && !vga_vsync_o)
				break;
			prev = vga_vsync_o;
		end
		h = 0;
		v = video_pkg::V_SYNC_START;
		repeat (FRAME_CYCLES) begin
			check_value("vga_hsync_o", vga_hsync_o,
				!(h >= video_pkg::H_SYNC_START && h < video_pkg::H_SYNC_START + video_pkg::H_SYNC));
			check_value("vga_vsync_o", vga_vsync_o,
				!(v >= video_pkg::V_SYNC_START && v < video_pkg::V_SYNC_START + video_pkg::V_SYNC));
			w = v * 4 + h / 4;
			exp = 6'b0;
			if (h < video_pkg::H_VISIBLE && v < video_pkg::V_VISIBLE)
				exp = shadow[w][(h % 4) * 8 +: 6];
			check_value("colour", {vga_r_o, vga_g_o, vga_b_o}, exp);
			h++;
			if (h == video_pkg::LINE_CYCLES) begin
				h = 0;
				v = (v + 1) % video_pkg::FRAME_LINES;
			end
			@(negedge clk);
		end
	endtask

	task automatic irq_check();
		logic err;
		logic [31:0] rdata;
		check_value("video_irq_o", video_irq_o, 0);
		wait_rise(2);	// Line start, well clear of both sync entries
		bus_write(CONTROL_ADR, 32'h301, 4'h3);
		wait_rise(1);
		check_value("vga_hsync_o", vga_hsync_o, 1);
		@(negedge clk);
		check_value("vga_hsync_o", vga_hsync_o, 0);
		wait_rise(0);
		check_value("vga_vsync_o", vga_vsync_o, 1);
		@(negedge clk);
		check_value("vga_vsync_o", vga_vsync_o, 0);
		bus_write(CONTROL_ADR, 32'h001, 4'h3);
		check_value("video_irq_o", video_irq_o, 3);
		bus_cycle(1'b0, STATUS_ADR, 32'h0, 4'hf, err, rdata);
		check_value("wb_error_o", err, 0);
		check_value("wb_data_o", rdata, 32'h3);
		bus_write(STATUS_ADR, 32'h1, 4'hf);
		check_value("video_irq_o", video_irq_o, 2);
		bus_write(STATUS_ADR, 32'h2, 4'hf);
		check_value("video_irq_o", video_irq_o, 0);
		repeat (FRAME_CYCLES) begin
			@(negedge clk);
			check_value("video_irq_o", video_irq_o, 0);
		end
	endtask

	initial begin
		string lines [$];
		string line, cmd;
		int fd, n;
		logic [23:0] adr;
		logic [31:0] data, rdata;
		logic [3:0] sel;
		logic err;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		wb_sel_i = 4'h0;
		wb_adr_i = 24'h0;
		wb_data_i = $random(seed);
		for (int i = 0; i < 32; i++)
			shadow[i] = 32'h5a000000 ^ (i * 32'h00010203);	// Power-up fill of the bank model
		fd = $fopen("test/video_stim.txt", "r");
		assert (fd != 0) else stop_on_error("Cannot open the stimulus file");
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 1 && line[0] != "#")
				lines.push_back(line);
		end
		$fclose(fd);
		cycle_limit = 4 * FRAME_CYCLES + 20 * lines.size();
		@(negedge reset);
		foreach (lines[i]) begin
			n = $sscanf(lines[i], "%s %h %h %h", cmd, adr, data, sel);
			if (cmd == "write") begin
				bus_write(adr, data, sel);
			end else if (cmd == "read") begin
				bus_cycle(1'b0, adr, 32'h0, 4'hf, err, rdata);
				check_value("wb_error_o", err, 0);
				check_value("wb_data_o", rdata, data);
			end else if (cmd == "read-error") begin
				bus_cycle(1'b0, adr, 32'h0, 4'hf, err, rdata);
				check_value("wb_error_o", err, 1);
				check_value("wb_data_o", rdata, 32'hffffffff);
			end else if (cmd == "frame") begin
				frame_check();
			end else if (cmd == "irq") begin
				irq_check();
			end else begin
				stop_on_error({"Unknown stimulus command ", cmd});
			end
		end
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/video_stim.txt ====
# write <byte address> <data> <byte select> | read <byte address> <expected>
# read-error <byte address> | frame check | irq check   (all numbers in hex)
write 0000 04030201 f
write 0004 0c0b0a09 f
write 0010 3f2a1505 f
write 0014 11223344 f
write 0018 aabbccdd f
write 0018 00001122 3
read 0018 aabb1122
write 001c 55667788 f
write 001c 00990000 4
read 001c 55997788
write 0040 0102033f f
write 007c 2a2a2a2a f
read 0000 04030201
write 0800 deadbeef f
write 0800 00000012 1
read 0800 deadbe12
write 0ffc 12345678 f
read 0ffc 12345678
write 1000 00000301 f
read 1000 00000301
write 1000 00000000 2
read 1000 00000001
write 1000 ffffff00 1
read 1000 00000000
read-error 1008
read-error 2000
write 1000 00000001 1
frame check
irq check

// ==== project.f ====
design/video_pkg.sv
design/wb_periph_bridge.sv
design/video_memory.sv
design/vga_regs.sv
design/vga_timing.sv
design/video_top.sv
test/tb_clock.sv
test/sram_bank_model.sv
test/video_tb.sv
